// File: src/daq_pkg.sv
package daq_pkg;

  // Host command codes, arrive with cmd_strobe
  typedef enum logic [1:0] {
    CMD_NONE  = 2'd0,
    CMD_INIT  = 2'd1,  // Load row window
    CMD_START = 2'd2,
    CMD_STOP  = 2'd3   // Honoured at frame end
  } cmd_t;

  // Acquisition run state
  typedef enum logic [1:0] {
    ST_IDLE       = 2'd0,
    ST_CONFIGURED = 2'd1,  // Window loaded, not yet running
    ST_RUNNING    = 2'd2,
    ST_STOPPING   = 2'd3   // Waiting for end of frame
  } run_state_t;

  // One ADC channel sample
  localparam int SAMPLE_W = 16;

  // Event buffer word, two packed samples
  localparam int WORD_W = 32;

  // Row index, 64 rows per frame
  localparam int ROW_W = 6;

  // Init argument
  // Bits 5..0 first row of window
  // Bits 11..6 last row of window
  localparam int CMD_ARG_W = 12;

  // Field offsets inside cmd_arg
  localparam int ARG_FIRST_LSB = 0;
  localparam int ARG_LAST_LSB  = ROW_W;

endpackage

// File: src/run_control.sv
`timescale 1ns/1ps

module run_control
  import daq_pkg::*;
(
  input  logic                 clk100M,
  input  logic                 rst_command,
  input  logic                 cmd_strobe,       // One-cycle command pulse
  input  cmd_t                 cmd_code,
  input  logic [CMD_ARG_W-1:0] cmd_arg,          // Row window for init
  input  logic                 frame_last_word,  // From packer
  output run_state_t           run_state,
  output logic                 run_write_en,     // Buffer writes allowed
  output logic [ROW_W-1:0]     row_first,
  output logic [ROW_W-1:0]     row_last
);

  run_state_t state_d;
  logic       window_loaded;  // Set once any init was seen
  logic       init_cmd;
  logic       start_cmd;
  logic       stop_cmd;

  // Commands count only with the strobe
  assign init_cmd  = cmd_strobe && (cmd_code == CMD_INIT);
  assign start_cmd = cmd_strobe && (cmd_code == CMD_START);
  assign stop_cmd  = cmd_strobe && (cmd_code == CMD_STOP);

  // Next-state logic
  always_comb begin
    state_d = run_state;  // Hold by default
    case (run_state)
      ST_IDLE: begin
        if (init_cmd) begin
          state_d = ST_CONFIGURED;
        end else if (start_cmd && window_loaded) begin
          state_d = ST_RUNNING;  // Restart with old window
        end
      end
      ST_CONFIGURED: begin
        // Re-init only reloads the window
        if (start_cmd) begin
          state_d = ST_RUNNING;
        end
      end
      ST_RUNNING: begin
        if (stop_cmd) begin
          state_d = ST_STOPPING;  // Init and start ignored here
        end
      end
      ST_STOPPING: begin
        // Leave only after last word of window went out
        if (frame_last_word) begin
          state_d = ST_IDLE;
        end
      end
      default: state_d = ST_IDLE;
    endcase
  end

  // State register
  always_ff @(posedge clk100M) begin
    if (rst_command) begin
      run_state <= ST_IDLE;
    end else begin
      run_state <= state_d;
    end
  end

  // Row window latched at init
  always_ff @(posedge clk100M) begin
    if (rst_command) begin
      row_first     <= '0;  // Window 0..0 after reset
      row_last      <= '0;
      window_loaded <= 1'b0;
    end else if (init_cmd &&
                 (run_state == ST_IDLE || run_state == ST_CONFIGURED)) begin
      row_first     <= cmd_arg[ARG_FIRST_LSB +: ROW_W];
      row_last      <= cmd_arg[ARG_LAST_LSB +: ROW_W];
      window_loaded <= 1'b1;
    end
  end

  // Writes stay open until the frame in flight is done
  assign run_write_en = (run_state == ST_RUNNING) || (run_state == ST_STOPPING);

endmodule

// File: src/frame_packer.sv
`timescale 1ns/1ps

module frame_packer
  import daq_pkg::*;
#(
  parameter int NUM_CHANNELS = 4  // Must be even
) (
  input  logic                             clk100M,
  input  logic                             rst_command,
  input  logic                             sample_strobe,  // One pulse per row
  input  logic [NUM_CHANNELS*SAMPLE_W-1:0] sample_data,    // Ch 0 in low bits
  input  logic [ROW_W-1:0]                 row_first,
  input  logic [ROW_W-1:0]                 row_last,
  output logic                             word_valid,
  output logic [WORD_W-1:0]                word_data,
  output logic                             frame_last_word  // Last word of row_last
);

  localparam int WORDS  = NUM_CHANNELS / 2;    // Packed words per row
  localparam int CNT_W  = $clog2(WORDS + 1);
  localparam int DATA_W = NUM_CHANNELS * SAMPLE_W;

  logic [ROW_W-1:0]  row_cnt;      // Row of the next strobe
  logic [CNT_W-1:0]  words_left;   // Words still in shift_q
  logic              last_row_q;   // Current row is row_last
  logic [DATA_W-1:0] shift_q;      // Remaining samples of the row
  logic              in_window;
  logic              hit_last;
  logic              load_row;
  logic              shift_word;

  // Window check against the row being strobed now
  assign in_window = (row_cnt >= row_first) && (row_cnt <= row_last);
  assign hit_last  = (row_cnt == row_last);

  // New row wins, earlier row is already drained at min strobe spacing
  assign load_row   = sample_strobe && in_window;
  assign shift_word = !load_row && (words_left != '0);

  // Row counter and word sequencing
  always_ff @(posedge clk100M) begin
    if (rst_command) begin
      row_cnt         <= '0;
      words_left      <= '0;
      last_row_q      <= 1'b0;
      word_valid      <= 1'b0;
      frame_last_word <= 1'b0;
    end else begin
      word_valid      <= 1'b0;
      frame_last_word <= 1'b0;
      if (sample_strobe) begin
        row_cnt <= row_cnt + 1'b1;  // Wraps 63 -> 0
      end
      if (load_row) begin
        word_valid      <= 1'b1;    // Word 0 next cycle
        words_left      <= CNT_W'(WORDS - 1);
        last_row_q      <= hit_last;
        frame_last_word <= hit_last && (WORDS == 1);
      end else if (shift_word) begin
        word_valid      <= 1'b1;
        words_left      <= words_left - 1'b1;
        frame_last_word <= last_row_q && (words_left == CNT_W'(1));
      end
    end
  end

  // Sample path, pair 2k/2k+1 goes out as word k
  always_ff @(posedge clk100M) begin
    if (load_row) begin
      word_data <= sample_data[WORD_W-1:0];
      shift_q   <= sample_data >> WORD_W;   // Drop the pair just sent
    end else if (shift_word) begin
      word_data <= shift_q[WORD_W-1:0];
      shift_q   <= shift_q >> WORD_W;
    end
  end

endmodule

// File: src/event_fifo.sv
`timescale 1ns/1ps

module event_fifo
  import daq_pkg::*;
#(
  parameter int FIFO_DEPTH = 16
) (
  input  logic              clk100M,
  input  logic              rst_command,
  input  logic              wr_en,
  input  logic [WORD_W-1:0] wr_data,
  input  logic              rd_en,    // Pops oldest word
  output logic [WORD_W-1:0] rd_data,  // Oldest word, valid when !empty
  output logic              empty,
  output logic              full
);

  localparam int ADDR_W  = (FIFO_DEPTH > 1) ? $clog2(FIFO_DEPTH) : 1;
  localparam int COUNT_W = $clog2(FIFO_DEPTH + 1);

  logic [WORD_W-1:0]  mem [FIFO_DEPTH];
  logic [ADDR_W-1:0]  wr_ptr;
  logic [ADDR_W-1:0]  rd_ptr;
  logic [COUNT_W-1:0] count;   // Words held
  logic               do_wr;
  logic               do_rd;

  assign do_wr = wr_en && !full;   // Drop on full
  assign do_rd = rd_en && !empty;  // Ignore pop on empty

  // Storage
  always_ff @(posedge clk100M) begin
    if (do_wr) begin
      mem[wr_ptr] <= wr_data;
    end
  end

  // Pointers wrap at depth, not at power of two
  always_ff @(posedge clk100M) begin
    if (rst_command) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
      count  <= '0;
    end else begin
      if (do_wr) begin
        wr_ptr <= (wr_ptr == ADDR_W'(FIFO_DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
      end
      if (do_rd) begin
        rd_ptr <= (rd_ptr == ADDR_W'(FIFO_DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
      end
      if (do_wr && !do_rd) begin
        count <= count + 1'b1;
      end else if (do_rd && !do_wr) begin
        count <= count - 1'b1;
      end
    end
  end

  // First-word-fall-through output
  assign rd_data = mem[rd_ptr];
  assign empty   = (count == '0);
  assign full    = (count == COUNT_W'(FIFO_DEPTH));

endmodule

// File: src/acq_write_gate.sv
`timescale 1ns/1ps

module acq_write_gate
  import daq_pkg::*;
#(
  parameter int VETO_HOLDOFF = 450,  // Cycles after reset
  parameter int FIFO_DEPTH   = 16
) (
  input  logic              clk100M,
  input  logic              rst_command,
  input  logic              word_valid,    // Packer strobe
  input  logic [WORD_W-1:0] word_data,
  input  logic              run_write_en,  // From run FSM
  input  logic              rd_en,
  output logic [WORD_W-1:0] rd_data,
  output logic              empty,
  output logic              overflow_veto
);

  localparam int HOLD_W = $clog2(VETO_HOLDOFF + 1);

  logic [HOLD_W-1:0] holdoff_cnt;
  logic              holdoff_done;
  logic              fifo_full;
  logic              fifo_wr_en;

  // Veto: hold-off after reset, then sticky once full
  always_ff @(posedge clk100M) begin
    if (rst_command) begin
      holdoff_cnt   <= '0;
      holdoff_done  <= 1'b0;
      overflow_veto <= 1'b1;  // Blocked from reset on
    end else if (!holdoff_done) begin
      if (holdoff_cnt == HOLD_W'(VETO_HOLDOFF - 1)) begin
        holdoff_done  <= 1'b1;
        overflow_veto <= 1'b0;  // Open after VETO_HOLDOFF cycles
      end else begin
        holdoff_cnt <= holdoff_cnt + 1'b1;
      end
    end else if (fifo_full) begin
      overflow_veto <= 1'b1;  // Until next reset
    end
  end

  // Nothing stalls upstream, gated words are lost
  assign fifo_wr_en = word_valid && run_write_en && !overflow_veto;

  event_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_event_fifo (
    .clk100M     (clk100M),
    .rst_command (rst_command),
    .wr_en       (fifo_wr_en),
    .wr_data     (word_data),
    .rd_en       (rd_en),
    .rd_data     (rd_data),
    .empty       (empty),
    .full        (fifo_full)
  );

endmodule

// File: src/daq_top.sv
`timescale 1ns/1ps

module daq_top
  import daq_pkg::*;
#(
  parameter int NUM_CHANNELS = 4,    // Even channel count
  parameter int VETO_HOLDOFF = 450,
  parameter int FIFO_DEPTH   = 16
) (
  input  logic                             clk100M,
  input  logic                             rst_command,
  input  logic                             cmd_strobe,
  input  cmd_t                             cmd_code,
  input  logic [CMD_ARG_W-1:0]             cmd_arg,
  input  logic                             sample_strobe,
  input  logic [NUM_CHANNELS*SAMPLE_W-1:0] sample_data,
  input  logic                             rd_en,
  output logic [WORD_W-1:0]                rd_data,
  output logic                             empty,
  output logic                             overflow_veto,
  output run_state_t                       run_state
);

  logic              run_write_en;
  logic [ROW_W-1:0]  row_first;
  logic [ROW_W-1:0]  row_last;
  logic              word_valid;
  logic [WORD_W-1:0] word_data;
  logic              frame_last_word;  // Packer -> FSM, ends a stop

  run_control u_run_control (
    .clk100M         (clk100M),
    .rst_command     (rst_command),
    .cmd_strobe      (cmd_strobe),
    .cmd_code        (cmd_code),
    .cmd_arg         (cmd_arg),
    .frame_last_word (frame_last_word),
    .run_state       (run_state),
    .run_write_en    (run_write_en),
    .row_first       (row_first),
    .row_last        (row_last)
  );

  frame_packer #(
    .NUM_CHANNELS (NUM_CHANNELS)
  ) u_frame_packer (
    .clk100M         (clk100M),
    .rst_command     (rst_command),
    .sample_strobe   (sample_strobe),
    .sample_data     (sample_data),
    .row_first       (row_first),
    .row_last        (row_last),
    .word_valid      (word_valid),
    .word_data       (word_data),
    .frame_last_word (frame_last_word)
  );

  acq_write_gate #(
    .VETO_HOLDOFF (VETO_HOLDOFF),
    .FIFO_DEPTH   (FIFO_DEPTH)
  ) u_acq_write_gate (
    .clk100M       (clk100M),
    .rst_command   (rst_command),
    .word_valid    (word_valid),
    .word_data     (word_data),
    .run_write_en  (run_write_en),
    .rd_en         (rd_en),
    .rd_data       (rd_data),
    .empty         (empty),
    .overflow_veto (overflow_veto)
  );

endmodule

// File: tb/daq_model.svh
`ifndef DAQ_MODEL_SVH
`define DAQ_MODEL_SVH

// Expected buffer words, oldest first
logic [WORD_W-1:0] exp_q[$];

logic [ROW_W-1:0] m_row;    // Row of the next strobe
logic [ROW_W-1:0] m_first;  // Window bounds
logic [ROW_W-1:0] m_last;
logic             m_loaded; // Window seen since reset
run_state_t       m_state;
logic             m_veto;
int               m_count;  // Words held in the buffer

// Everything back to power-up values
task automatic model_reset();
  exp_q.delete();
  m_row    = '0;
  m_first  = '0;
  m_last   = '0;
  m_loaded = 1'b0;
  m_state  = ST_IDLE;
  m_veto   = 1'b1;
  m_count  = 0;
endtask

// Run state rules for one command
task automatic model_cmd(input cmd_t code, input logic [CMD_ARG_W-1:0] arg);
  if (code == CMD_INIT && (m_state == ST_IDLE || m_state == ST_CONFIGURED)) begin
    m_first  = arg[ROW_W-1:0];
    m_last   = arg[2*ROW_W-1:ROW_W];
    m_loaded = 1'b1;
    m_state  = ST_CONFIGURED;
  end else if (code == CMD_START &&
               (m_state == ST_CONFIGURED || (m_state == ST_IDLE && m_loaded))) begin
    m_state = ST_RUNNING;
  end else if (code == CMD_STOP && m_state == ST_RUNNING) begin
    m_state = ST_STOPPING;
  end
endtask

// One sensor row, queues the words that should reach the buffer
task automatic model_row(input logic [NUM_CH*SAMPLE_W-1:0] data);
  logic [WORD_W-1:0] w;
  logic              in_win;
  logic              run_en;
  in_win = (m_row >= m_first) && (m_row <= m_last);
  run_en = (m_state == ST_RUNNING) || (m_state == ST_STOPPING);
  if (in_win && run_en) begin
    for (int k = 0; k < NUM_CH / 2; k++) begin
      w = {data[(2*k+1)*SAMPLE_W +: SAMPLE_W], data[2*k*SAMPLE_W +: SAMPLE_W]};
      if (!m_veto && m_count < DEPTH) begin
        exp_q.push_back(w);
        m_count++;
        if (m_count == DEPTH) begin
          m_veto = 1'b1;  // Sticky until reset
        end
      end
    end
  end
  if (in_win && m_row == m_last && m_state == ST_STOPPING) begin
    m_state = ST_IDLE;  // Frame done, stop completes
  end
  m_row = m_row + 1'b1;  // Wraps at 64
endtask

`endif

// File: tb/daq_tb.sv
`timescale 1ns/1ps

module daq_tb
  import daq_pkg::*;
;

  localparam int NUM_CH  = 4;    // Same as DUT defaults
  localparam int HOLDOFF = 450;
  localparam int DEPTH   = 16;

  logic                       clk100M;
  logic                       rst_command;
  logic                       cmd_strobe;
  cmd_t                       cmd_code;
  logic [CMD_ARG_W-1:0]       cmd_arg;
  logic                       sample_strobe;
  logic [NUM_CH*SAMPLE_W-1:0] sample_data;
  logic                       rd_en;
  logic [WORD_W-1:0]          rd_data;
  logic                       empty;
  logic                       overflow_veto;
  run_state_t                 run_state;

  int          checks;
  int          errors;
  int          test_errs;
  int          words_read;  // Words popped from the DUT
  logic        reader_on;
  int unsigned lcg_state;

  `include "daq_model.svh"

  daq_top uut (
    .clk100M       (clk100M),
    .rst_command   (rst_command),
    .cmd_strobe    (cmd_strobe),
    .cmd_code      (cmd_code),
    .cmd_arg       (cmd_arg),
    .sample_strobe (sample_strobe),
    .sample_data   (sample_data),
    .rd_en         (rd_en),
    .rd_data       (rd_data),
    .empty         (empty),
    .overflow_veto (overflow_veto),
    .run_state     (run_state)
  );

  always #5 clk100M = ~clk100M;  // 100 MHz

  function automatic int unsigned next_rand();
    lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
    return lcg_state;
  endfunction

  task automatic abort_on_timeout(input string what);
    $display("Timeout waiting for %s at %0t ns", what, $time);
    $display("Checks failed");
    $finish;
  endtask

  task automatic check_val(input string name, input logic [31:0] got,
                           input logic [31:0] exp);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("FAILED at %0t ns: %s got %0h expected %0h", $time, name, got, exp);
    end
  endtask

  // Reader checks the head word then pops it
  always begin
    @(negedge clk100M);
    if (reader_on && !empty) begin
      if (exp_q.size() == 0) begin
        checks++;
        errors++;
        $display("Word %h read at %0t ns while none was expected", rd_data, $time);
      end else begin
        check_val("rd_data", rd_data, exp_q[0]);
        exp_q.delete(0);
      end
      m_count--;
      words_read++;
      @(posedge clk100M) rd_en <= 1'b1;
      @(posedge clk100M) rd_en <= 1'b0;  // Pop taken at this edge
    end
  end

  task automatic apply_reset();
    @(posedge clk100M) rst_command <= 1'b1;
    repeat (2) @(posedge clk100M);
    rst_command <= 1'b0;
    model_reset();
  endtask

  // Counts cycles to veto release
  // First negedge sees the reset values
  task automatic wait_holdoff();
    int n;
    n = 0;
    do begin
      @(negedge clk100M);
      n++;
      if (n == 1) begin
        check_val("run_state", 32'(run_state), 32'(ST_IDLE));
        check_val("empty", 32'(empty), 32'd1);
        check_val("overflow_veto", 32'(overflow_veto), 32'd1);
      end
      if (n > HOLDOFF + 50) abort_on_timeout("hold-off release");
    end while (overflow_veto);
    check_val("holdoff_cycles", 32'(n), 32'(HOLDOFF + 1));
    m_veto = 1'b0;
  endtask

  task automatic send_cmd(input cmd_t code, input logic [CMD_ARG_W-1:0] arg);
    @(posedge clk100M);
    cmd_strobe <= 1'b1;
    cmd_code   <= code;
    cmd_arg    <= arg;
    model_cmd(code, arg);
    @(posedge clk100M);
    cmd_strobe <= 1'b0;
    cmd_code   <= CMD_NONE;
    @(negedge clk100M);
    check_val("run_state", 32'(run_state), 32'(m_state));
  endtask

  // One strobe and 3 idle cycles
  task automatic send_row();
    logic [NUM_CH*SAMPLE_W-1:0] d;
    d = {next_rand(), next_rand()};
    @(posedge clk100M);
    sample_strobe <= 1'b1;
    sample_data   <= d;
    model_row(d);
    @(posedge clk100M) sample_strobe <= 1'b0;
    repeat (2) @(posedge clk100M);
  endtask

  task automatic send_rows(input int n);
    repeat (n) send_row();
  endtask

  task automatic wait_drain();
    int n;
    n = 0;
    while (exp_q.size() != 0 || !empty) begin
      @(negedge clk100M);
      n++;
      if (n > 4000) abort_on_timeout("buffer drain");
    end
    repeat (4) @(negedge clk100M);  // Catch stray late words
  endtask

  task automatic init_random_window();
    logic [ROW_W-1:0] first;
    logic [ROW_W-1:0] last;
    first = ROW_W'(next_rand() % 32);
    last  = first + ROW_W'(next_rand() % 6);
    send_cmd(CMD_INIT, {last, first});
  endtask

  task automatic end_test(input int num, input string name);
    $display("Test %0d %s: %0d errors", num, name, errors - test_errs);
    test_errs = errors;
  endtask

  initial begin
    int guard;
    clk100M       = 1'b0;
    rst_command   = 1'b1;
    cmd_strobe    = 1'b0;
    cmd_code      = CMD_NONE;
    cmd_arg       = '0;
    sample_strobe = 1'b0;
    sample_data   = '0;
    rd_en         = 1'b0;
    reader_on     = 1'b1;
    checks        = 0;
    errors        = 0;
    test_errs     = 0;
    words_read    = 0;
    lcg_state     = 3;
    model_reset();

    // Reset values, hold-off and silence before start
    apply_reset();
    wait_holdoff();
    send_rows(70);
    wait_drain();
    check_val("empty", 32'(empty), 32'd1);
    end_test(1, "reset and hold-off");

    // Random window over two frames
    init_random_window();
    send_cmd(CMD_START, '0);
    send_rows(128);
    wait_drain();
    end_test(2, "window packing");

    // Stop once inside the window
    guard = 0;
    while (!(m_row >= m_first && m_row <= m_last)) begin
      send_row();
      guard++;
      if (guard > 64) abort_on_timeout("window row");
    end
    send_cmd(CMD_STOP, '0);
    send_rows(64);
    wait_drain();
    check_val("run_state", 32'(run_state), 32'(ST_IDLE));
    send_rows(64);
    wait_drain();
    end_test(3, "stop at frame end");

    // Reader idle until the buffer overflows
    reader_on = 1'b0;
    send_cmd(CMD_START, '0);
    guard = 0;
    while (m_count < DEPTH) begin
      send_row();
      guard++;
      if (guard > 1024) abort_on_timeout("buffer fill");
    end
    send_rows(64);  // Extra words are all lost
    @(negedge clk100M);
    check_val("overflow_veto", 32'(overflow_veto), 32'd1);
    words_read = 0;
    reader_on  = 1'b1;
    wait_drain();
    check_val("words_read", 32'(words_read), 32'(DEPTH));
    send_rows(64);
    wait_drain();
    check_val("overflow_veto", 32'(overflow_veto), 32'd1);
    end_test(4, "overflow veto");

    // Reset during a run with words still buffered
    apply_reset();  // Reopens the sticky veto
    wait_holdoff();
    init_random_window();
    send_cmd(CMD_START, '0);
    reader_on = 1'b0;
    send_rows(64);
    repeat (4) @(posedge clk100M);
    check_val("empty", 32'(empty), 32'(exp_q.size() == 0));
    apply_reset();
    wait_holdoff();
    reader_on = 1'b1;
    send_cmd(CMD_START, '0);  // Ignored without a window
    init_random_window();
    send_cmd(CMD_START, '0);
    send_rows(64);
    wait_drain();
    end_test(5, "reset mid-run");

    $display("Tests 5, checks %0d, errors %0d", checks, errors);
    if (errors == 0) begin
      $display("All checks passed");
    end else begin
      $display("Checks failed");
    end
    $finish;
  end

endmodule

// File: daq_top.f
+incdir+tb
src/daq_pkg.sv
src/run_control.sv
src/frame_packer.sv
src/event_fifo.sv
src/acq_write_gate.sv
src/daq_top.sv
tb/daq_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the testbench with Verilator
cd "$(dirname "$0")" &&
verilator --binary --timing -Wno-fatal --top-module daq_tb -f daq_top.f -o daq_sim &&
out="$(./obj_dir/daq_sim)" || { echo "$out"; echo "Simulation did not run"; exit 1; }
echo "$out"
echo "$out" | grep -q "All checks passed" && exit 0 || exit 1
